// ==== include/phy_init_table.svh ====
`ifndef PHY_INIT_TABLE_SVH
`define PHY_INIT_TABLE_SVH

// command for one step of the PHY init sequence
// steps 0 to 11 are three indirect writes of four commands each
function automatic mdio_cmd_t init_cmd(input init_step_t step);
    mdio_cmd_t   cmd;
    logic [15:0] ext_addr;
    logic [15:0] ext_data;

    case (step[3:2])
        2'd0: begin
            // CFG4, SGMII autoneg timer to 11 ms
            ext_addr = 16'h0031;
            ext_data = 16'h0070;
        end
        2'd1: begin
            // SGMIICTL1, SGMII clock output on
            ext_addr = 16'h00D3;
            ext_data = 16'h4000;
        end
        default: begin
            // 10M_SGMII_CFG, allow 10 Mbps over SGMII
            ext_addr = 16'h016F;
            ext_data = 16'h0015;
        end
    endcase

    cmd.opcode   = MDIO_OP_WRITE;
    cmd.phy_addr = PHY_ADDR;
    case (step[1:0])
        2'd0: begin
            cmd.reg_addr = REG_REGCR;
            cmd.data     = REGCR_ADDR_MODE;
        end
        2'd1: begin
            cmd.reg_addr = REG_ADDAR;
            cmd.data     = ext_addr;
        end
        2'd2: begin
            cmd.reg_addr = REG_REGCR;
            cmd.data     = REGCR_DATA_MODE;
        end
        default: begin
            cmd.reg_addr = REG_ADDAR;
            cmd.data     = ext_data;
        end
    endcase

    if (step == init_step_t'(INIT_CMD_COUNT - 2)) begin
        // read back PHYCR before touching it
        cmd.opcode   = MDIO_OP_READ;
        cmd.reg_addr = REG_PHYCR;
        cmd.data     = 16'h0000;
    end else if (step >= init_step_t'(INIT_CMD_COUNT - 1)) begin
        // set SGMII_EN in PHYCR
        cmd.reg_addr = REG_PHYCR;
        cmd.data     = 16'h0800;
    end

    return cmd;
endfunction

`endif

// ==== design/phy_mgmt_pkg.sv ====
`default_nettype none

package phy_mgmt_pkg;

    // clause-22 opcodes
    localparam logic [1:0] MDIO_OP_WRITE = 2'b01;
    localparam logic [1:0] MDIO_OP_READ  = 2'b10;

    // strap address of the on-board PHY
    localparam logic [4:0] PHY_ADDR = 5'd3;

    // register map used by the init sequence
    localparam logic [4:0] REG_REGCR = 5'h0D;
    localparam logic [4:0] REG_ADDAR = 5'h0E;
    localparam logic [4:0] REG_PHYCR = 5'h10;

    // REGCR function select, address then data without post increment
    localparam logic [15:0] REGCR_ADDR_MODE = 16'h001F;
    localparam logic [15:0] REGCR_DATA_MODE = 16'h401F;

    localparam int INIT_CMD_COUNT    = 14;
    localparam int INIT_DELAY_CYCLES = 256;
    localparam int INIT_DELAY_W      = $clog2(INIT_DELAY_CYCLES);

    // one MDIO bit is two half periods of MDC
    localparam int MDC_HALF_PERIOD = 4;
    localparam int MDC_DIV_W       = $clog2(MDC_HALF_PERIOD);

    // frame layout, bit 0 is the first preamble bit on the wire
    localparam int MDIO_FRAME_BITS = 64;
    localparam int MDIO_BIT_W      = $clog2(MDIO_FRAME_BITS);
    localparam int MDIO_TA_BIT     = 46;
    localparam int MDIO_DATA_BIT   = 48;

    typedef logic [3:0] init_step_t;

    typedef struct packed {
        logic [1:0]  opcode;
        logic [4:0]  phy_addr;
        logic [4:0]  reg_addr;
        logic [15:0] data;
    } mdio_cmd_t;

endpackage

`default_nettype wire

// ==== design/phy_init_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module phy_init_sequencer
    import phy_mgmt_pkg::*;
(
    input  logic      clk_125mhz_int,
    input  logic      rst_125mhz_int,
    input  logic      cmd_ready_i,
    output mdio_cmd_t cmd_o,
    output logic      cmd_valid_o,
    output logic      init_done_o
);

`include "phy_init_table.svh"

    typedef enum logic [1:0] {
        SEQ_DELAY,
        SEQ_ISSUE,
        SEQ_DRAIN,
        SEQ_DONE
    } seq_state_t;

    seq_state_t              state;
    logic [INIT_DELAY_W-1:0] delay_cnt;
    init_step_t              step;
    logic                    delay_last;
    logic                    step_last;
    logic                    cmd_fire;

    assign delay_last = delay_cnt == INIT_DELAY_W'(INIT_DELAY_CYCLES - 1);
    assign step_last  = step == init_step_t'(INIT_CMD_COUNT - 1);
    assign cmd_fire   = cmd_valid_o && cmd_ready_i;

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            state     <= SEQ_DELAY;
            delay_cnt <= '0;
            step      <= '0;
        end else begin
            case (state)
                SEQ_DELAY: begin
                    // PHY needs time out of its own reset
                    if (delay_last) begin
                        state <= SEQ_ISSUE;
                    end else begin
                        delay_cnt <= delay_cnt + INIT_DELAY_W'(1);
                    end
                end
                SEQ_ISSUE: begin
                    // next command is up the cycle after each transfer
                    if (cmd_fire) begin
                        if (step_last) begin
                            state <= SEQ_DRAIN;
                        end else begin
                            step <= step + init_step_t'(1);
                        end
                    end
                end
                SEQ_DRAIN: begin
                    // last frame still on the wire
                    if (cmd_ready_i) begin
                        state <= SEQ_DONE;
                    end
                end
                default: begin
                    state <= SEQ_DONE;
                end
            endcase
        end
    end

    // command follows the step register, stable while valid waits
    assign cmd_o       = init_cmd(step);
    assign cmd_valid_o = state == SEQ_ISSUE;
    assign init_done_o = state == SEQ_DONE;

endmodule

`default_nettype wire

// ==== design/mdio_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module mdio_master
    import phy_mgmt_pkg::*;
(
    input  logic        clk_125mhz_int,
    input  logic        rst_125mhz_int,
    input  mdio_cmd_t   cmd_i,
    input  logic        cmd_valid_i,
    output logic        cmd_ready_o,
    output logic [15:0] read_data_o,
    output logic        read_valid_o,
    output logic        busy_o,
    output logic        mdc_o,
    output logic        mdio_o,
    output logic        mdio_oe_o,
    input  logic        mdio_i
);

    logic                       active;
    logic                       is_read;
    logic                       mdc;
    logic [MDC_DIV_W-1:0]       div_cnt;
    logic [MDIO_BIT_W-1:0]      bit_cnt;
    logic [MDIO_FRAME_BITS-1:0] frame_sr;
    logic [15:0]                rd_sr;
    logic                       rd_valid;
    logic                       cmd_fire;
    logic                       half_done;
    logic                       fall_edge;
    logic                       rise_edge;
    logic                       bit_last;
    logic                       rd_release;
    logic                       rd_data_phase;

    assign cmd_fire  = cmd_valid_i && cmd_ready_o;
    assign half_done = div_cnt == MDC_DIV_W'(MDC_HALF_PERIOD - 1);
    assign bit_last  = bit_cnt == MDIO_BIT_W'(MDIO_FRAME_BITS - 1);

    // edges of MDC as they are about to happen on this clock
    assign fall_edge = active && half_done && mdc;
    assign rise_edge = active && half_done && !mdc;

    // PHY owns the line from turnaround to the end of a read
    assign rd_release    = is_read && (bit_cnt >= MDIO_BIT_W'(MDIO_TA_BIT));
    assign rd_data_phase = is_read && (bit_cnt >= MDIO_BIT_W'(MDIO_DATA_BIT));

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            active   <= 1'b0;
            is_read  <= 1'b0;
            mdc      <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= 1'b0;
            if (cmd_fire) begin
                active  <= 1'b1;
                is_read <= cmd_i.opcode == MDIO_OP_READ;
                mdc     <= 1'b0;
                div_cnt <= '0;
                bit_cnt <= '0;
            end else if (active) begin
                if (half_done) begin
                    div_cnt <= '0;
                    mdc     <= ~mdc;
                    if (mdc) begin
                        // falling edge closes the current bit
                        if (bit_last) begin
                            active   <= 1'b0;
                            rd_valid <= is_read;
                        end else begin
                            bit_cnt <= bit_cnt + MDIO_BIT_W'(1);
                        end
                    end
                end else begin
                    div_cnt <= div_cnt + MDC_DIV_W'(1);
                end
            end
        end
    end

    // frame shifter, MSB goes out first
    always_ff @(posedge clk_125mhz_int) begin
        if (cmd_fire) begin
            frame_sr <= {{(MDIO_FRAME_BITS / 2){1'b1}},
                         2'b01,
                         cmd_i.opcode,
                         cmd_i.phy_addr,
                         cmd_i.reg_addr,
                         2'b10,
                         cmd_i.data};
        end else if (fall_edge) begin
            frame_sr <= {frame_sr[MDIO_FRAME_BITS-2:0], 1'b0};
        end
    end

    // read capture at rising MDC, mid bit
    always_ff @(posedge clk_125mhz_int) begin
        if (rise_edge && rd_data_phase) begin
            rd_sr <= {rd_sr[14:0], mdio_i};
        end
    end

    assign cmd_ready_o  = !active;
    assign busy_o       = active;
    assign mdc_o        = mdc;
    assign mdio_o       = active ? frame_sr[MDIO_FRAME_BITS-1] : 1'b1;
    assign mdio_oe_o    = active && !rd_release;
    assign read_data_o  = rd_sr;
    assign read_valid_o = rd_valid;

endmodule

`default_nettype wire

// ==== design/phy_mgmt_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module phy_mgmt_top
    import phy_mgmt_pkg::*;
(
    input  logic        clk_125mhz_int,
    input  logic        rst_125mhz_int,
    output logic        mdc_o,
    output logic        mdio_o,
    output logic        mdio_oe_o,
    input  logic        mdio_i,
    output logic [15:0] read_data_o,
    output logic        read_valid_o,
    output logic        busy_o,
    output logic        init_done_o
);

    mdio_cmd_t init_cmd;
    logic      init_cmd_valid;
    logic      init_cmd_ready;

    // fixed PHY bring-up commands
    phy_init_sequencer u_sequencer (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .cmd_ready_i    (init_cmd_ready),
        .cmd_o          (init_cmd),
        .cmd_valid_o    (init_cmd_valid),
        .init_done_o    (init_done_o)
    );

    // clause-22 frame engine, one command at a time
    mdio_master u_mdio_master (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .cmd_i          (init_cmd),
        .cmd_valid_i    (init_cmd_valid),
        .cmd_ready_o    (init_cmd_ready),
        .read_data_o    (read_data_o),
        .read_valid_o   (read_valid_o),
        .busy_o         (busy_o),
        .mdc_o          (mdc_o),
        .mdio_o         (mdio_o),
        .mdio_oe_o      (mdio_oe_o),
        .mdio_i         (mdio_i)
    );

endmodule

`default_nettype wire

// ==== verification/phy_mdio_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module phy_mdio_model
    import phy_mgmt_pkg::*;
#(
    parameter logic [15:0] READ_VALUE = 16'h0000
) (
    input  logic      clk_125mhz_int,
    input  logic      rst_125mhz_int,
    input  logic      mdc_i,
    input  logic      mdio_i,
    output logic      mdio_drv_o,
    output logic      mdio_drv_en_o,
    output mdio_cmd_t frame_o,
    output logic      frame_valid_o,
    output logic      frame_ok_o
);

    logic        mdc_q;
    logic [6:0]  bit_cnt;
    logic [63:0] bits;
    logic [63:0] full;
    logic        rd_frame;
    logic        mdc_rise;
    logic        mdc_fall;
    logic [3:0]  data_idx;

    assign mdc_rise = mdc_i && !mdc_q;
    assign mdc_fall = !mdc_i && mdc_q;
    // frame as it stands with the bit sampled now
    assign full     = {bits[62:0], mdio_i};
    assign data_idx = 4'(7'd63 - bit_cnt);

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            mdc_q         <= 1'b0;
            bit_cnt       <= '0;
            bits          <= '0;
            rd_frame      <= 1'b0;
            mdio_drv_o    <= 1'b1;
            mdio_drv_en_o <= 1'b0;
            frame_o       <= '0;
            frame_valid_o <= 1'b0;
            frame_ok_o    <= 1'b0;
        end else begin
            mdc_q         <= mdc_i;
            frame_valid_o <= 1'b0;
            if (mdc_rise) begin
                bits <= full;
                // second opcode bit tells a read apart
                if (bit_cnt == 7'd35) begin
                    rd_frame <= full[1:0] == MDIO_OP_READ;
                end
                if (bit_cnt == 7'd63) begin
                    bit_cnt       <= '0;
                    rd_frame      <= 1'b0;
                    frame_valid_o <= 1'b1;
                    frame_o       <= mdio_cmd_t'({full[29:28], full[27:23], full[22:18],
                                                  full[15:0]});
                    // first turnaround bit of a read is not driven by anyone
                    frame_ok_o    <= (full[63:32] == {32{1'b1}}) && (full[31:30] == 2'b01)
                                     && !full[16] && (rd_frame || full[17]);
                end else begin
                    bit_cnt <= bit_cnt + 7'd1;
                end
            end
            if (mdc_fall) begin
                if (rd_frame && bit_cnt >= 7'd47) begin
                    mdio_drv_en_o <= 1'b1;
                    mdio_drv_o    <= (bit_cnt == 7'd47) ? 1'b0 : READ_VALUE[data_idx];
                end else begin
                    mdio_drv_en_o <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/phy_mgmt_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module phy_mgmt_assertions
    import phy_mgmt_pkg::*;
(
    input logic      clk_125mhz_int,
    input logic      rst_125mhz_int,
    input mdio_cmd_t cmd_i,
    input logic      cmd_valid_i,
    input logic      cmd_ready_i,
    input logic      busy_i,
    input logic      mdio_oe_i,
    input logic      init_done_i
);

    // command held until the master takes it
    a_valid_hold: assert property (@(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        cmd_valid_i && !cmd_ready_i |=> cmd_valid_i && $stable(cmd_i))
        else $error("cmd_valid dropped or cmd changed before ready");

    // once released inside a frame the line stays with the PHY
    a_oe_release: assert property (@(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        busy_i && !mdio_oe_i |=> !mdio_oe_i || !busy_i)
        else $error("mdio_oe rose again during a read data phase");

    a_done_sticky: assert property (@(posedge clk_125mhz_int) disable iff (rst_125mhz_int)
        init_done_i |=> init_done_i)
        else $error("init_done fell without reset");

endmodule

`default_nettype wire

// ==== verification/tb_phy_mgmt.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_phy_mgmt
    import phy_mgmt_pkg::*;
;

    localparam logic [15:0] PHYCR_VALUE    = 16'h5048;
    localparam int          TIMEOUT_CYCLES = 11400;
    localparam int          QUIET_CYCLES   = 1000;

    logic        clk_125mhz_int;
    logic        rst_125mhz_int;
    logic        mdc_o;
    logic        mdio_o;
    logic        mdio_oe_o;
    logic        mdio_line;
    logic [15:0] read_data_o;
    logic        read_valid_o;
    logic        busy_o;
    logic        init_done_o;
    logic        phy_drv;
    logic        phy_drv_en;
    mdio_cmd_t   seen_frame;
    logic        seen_valid;
    logic        seen_ok;

    int unsigned seed;
    int          cyc_cnt;
    int          frame_cnt;
    int          read_pulses;
    int          frame_err;
    int          read_err;
    int          misc_err;
    int          tests_passed;
    int          tests_failed;
    int          restart_base;

    always #4 clk_125mhz_int = ~clk_125mhz_int;

    // shared line, weak pull-up when nobody drives
    assign mdio_line = mdio_oe_o ? mdio_o : (phy_drv_en ? phy_drv : 1'b1);

    phy_mgmt_top DUT (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .mdc_o          (mdc_o),
        .mdio_o         (mdio_o),
        .mdio_oe_o      (mdio_oe_o),
        .mdio_i         (mdio_line),
        .read_data_o    (read_data_o),
        .read_valid_o   (read_valid_o),
        .busy_o         (busy_o),
        .init_done_o    (init_done_o)
    );

    phy_mdio_model #(.READ_VALUE(PHYCR_VALUE)) u_phy (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .mdc_i          (mdc_o),
        .mdio_i         (mdio_line),
        .mdio_drv_o     (phy_drv),
        .mdio_drv_en_o  (phy_drv_en),
        .frame_o        (seen_frame),
        .frame_valid_o  (seen_valid),
        .frame_ok_o     (seen_ok)
    );

    // handshake, line and done checks on the top level
    bind phy_mgmt_top phy_mgmt_assertions u_assertions (
        .clk_125mhz_int (clk_125mhz_int),
        .rst_125mhz_int (rst_125mhz_int),
        .cmd_i          (init_cmd),
        .cmd_valid_i    (init_cmd_valid),
        .cmd_ready_i    (init_cmd_ready),
        .busy_i         (busy_o),
        .mdio_oe_i      (mdio_oe_o),
        .init_done_i    (init_done_o)
    );

    // expected frame on the wire for each step
    function automatic mdio_cmd_t expected_cmd(input int idx);
        mdio_cmd_t   c;
        logic [15:0] ext_reg;
        logic [15:0] ext_val;

        case (idx / 4)
            0: begin
                ext_reg = 16'h0031;
                ext_val = 16'h0070;
            end
            1: begin
                ext_reg = 16'h00D3;
                ext_val = 16'h4000;
            end
            default: begin
                ext_reg = 16'h016F;
                ext_val = 16'h0015;
            end
        endcase
        c.opcode   = 2'b01;
        c.phy_addr = 5'd3;
        case (idx % 4)
            0: begin
                c.reg_addr = 5'h0D;
                c.data     = 16'h001F;
            end
            1: begin
                c.reg_addr = 5'h0E;
                c.data     = ext_reg;
            end
            2: begin
                c.reg_addr = 5'h0D;
                c.data     = 16'h401F;
            end
            default: begin
                c.reg_addr = 5'h0E;
                c.data     = ext_val;
            end
        endcase
        if (idx == 12) begin
            // data phase comes from the PHY
            c.opcode   = 2'b10;
            c.reg_addr = 5'h10;
            c.data     = PHYCR_VALUE;
        end else if (idx == 13) begin
            c.reg_addr = 5'h10;
            c.data     = 16'h0800;
        end
        return c;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp, input bit on_read);
        if (got != exp) begin
            $display("CHECK FAILED %s got %h expected %h (frame %0d)",
                     name, got, exp, frame_cnt);
            if (on_read) begin
                read_err++;
            end else begin
                frame_err++;
            end
        end
    endtask

    // compare every decoded frame and read pulse
    always @(posedge clk_125mhz_int) begin
        mdio_cmd_t exp;
        bit        on_read;

        if (rst_125mhz_int) begin
            frame_cnt   = 0;
            read_pulses = 0;
        end else begin
            if (seen_valid) begin
                if (frame_cnt >= INIT_CMD_COUNT) begin
                    $display("unexpected extra frame after the init sequence");
                    frame_err++;
                end else begin
                    exp     = expected_cmd(frame_cnt);
                    on_read = frame_cnt == 12;
                    check_value("opcode", {14'd0, seen_frame.opcode}, {14'd0, exp.opcode},
                                on_read);
                    check_value("phy_addr", {11'd0, seen_frame.phy_addr},
                                {11'd0, exp.phy_addr}, on_read);
                    check_value("reg_addr", {11'd0, seen_frame.reg_addr},
                                {11'd0, exp.reg_addr}, on_read);
                    check_value("data", seen_frame.data, exp.data, on_read);
                    if (!seen_ok) begin
                        $display("frame %0d has a bad preamble, start or turnaround",
                                 frame_cnt);
                        frame_err++;
                    end
                end
                frame_cnt++;
            end
            if (read_valid_o) begin
                read_pulses++;
                check_value("read_data_o", read_data_o, PHYCR_VALUE, 1'b1);
            end
        end
    end

    // each run restarts the budget at reset release
    always @(posedge clk_125mhz_int) begin
        if (rst_125mhz_int) begin
            cyc_cnt <= 0;
        end else begin
            cyc_cnt <= cyc_cnt + 1;
            if (cyc_cnt >= TIMEOUT_CYCLES) begin
                $display("timeout: init sequence did not finish within %0d cycles",
                         TIMEOUT_CYCLES);
                $display("Simulation finished: FAIL");
                $finish;
            end
        end
    end

    task automatic report_test(input string name, input int errs);
        if (errs == 0) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk_125mhz_int);
        #1 rst_125mhz_int = 1'b1;
        repeat (16) @(posedge clk_125mhz_int);
        #1 rst_125mhz_int = 1'b0;
    endtask

    task automatic check_quiet_startup();
        int errs;

        errs = 0;
        repeat (INIT_DELAY_CYCLES) begin
            @(negedge clk_125mhz_int);
            if (mdc_o || mdio_oe_o || init_done_o) begin
                $display("MDIO activity or done seen during the start-up delay");
                errs++;
            end
        end
        misc_err += errs;
        report_test("quiet start-up", errs);
    endtask

    task automatic wait_done();
        while (!init_done_o) begin
            @(negedge clk_125mhz_int);
        end
    endtask

    task automatic check_completion(input string name);
        int errs;

        errs = 0;
        if (frame_cnt != INIT_CMD_COUNT) begin
            $display("saw %0d frames instead of %0d", frame_cnt, INIT_CMD_COUNT);
            errs++;
        end
        if (busy_o) begin
            $display("CHECK FAILED busy_o got %h expected %h", busy_o, 1'b0);
            errs++;
        end
        repeat (QUIET_CYCLES) begin
            @(negedge clk_125mhz_int);
            if (mdc_o || mdio_oe_o || !init_done_o) begin
                $display("bus activity or done drop after the sequence ended");
                errs++;
            end
        end
        misc_err += errs;
        report_test(name, errs);
    endtask

    task automatic check_read(input string name, input int base);
        if (read_pulses != 1) begin
            $display("read_valid_o pulsed %0d times instead of once", read_pulses);
            read_err++;
        end
        report_test(name, read_err - base);
    endtask

    initial begin
        int base;

        seed           = 32'hb3ad8841;
        clk_125mhz_int = 1'b0;
        rst_125mhz_int = 1'b1;
        frame_err      = 0;
        read_err       = 0;
        misc_err       = 0;
        tests_passed   = 0;
        tests_failed   = 0;

        apply_reset();
        check_quiet_startup();
        wait_done();
        report_test("write frames", frame_err);
        check_read("PHYCR read", 0);
        check_completion("completion");

        // second run cut short in the middle of a frame
        restart_base = frame_err + read_err + misc_err;
        base         = read_err;
        apply_reset();
        while (frame_cnt < 3) begin
            @(negedge clk_125mhz_int);
        end
        repeat (100) @(negedge clk_125mhz_int);
        apply_reset();
        wait_done();
        check_read("restart read", base);
        check_completion("restart completion");
        report_test("restart", frame_err + read_err + misc_err - restart_base);

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && frame_err + read_err + misc_err == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
design/phy_mgmt_pkg.sv
design/phy_init_sequencer.sv
design/mdio_master.sv
design/phy_mgmt_top.sv
verification/phy_mdio_model.sv
verification/phy_mgmt_assertions.sv
verification/tb_phy_mgmt.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run tb_phy_mgmt and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f sources.f --top-module tb_phy_mgmt -Mdir obj_dir
	./obj_dir/Vtb_phy_mgmt | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
